/* common/memStagePkg.sv */
`default_nettype none

package memStagePkg;

	//////////////////////////////////////////////////////////////////////
	// Plain widths
	//////////////////////////////////////////////////////////////////////

	// One CPU data word
	typedef logic [31:0] dataWord_t;
	// Byte address as issued by execute
	typedef logic [31:0] addr_t;
	// One enable per byte lane
	typedef logic [3:0] byteSel_t;
	// Byte position inside a word
	typedef logic [1:0] byteOffset_t;

	//////////////////////////////////////////////////////////////////////
	// Access kinds
	//////////////////////////////////////////////////////////////////////

	// Same numbering as the load divider of the CPU
	typedef enum logic [2:0]
	{
		loadWord  = 3'd0,
		loadWordU = 3'd1,
		loadByte  = 3'd2,
		loadByteU = 3'd3,
		loadHalf  = 3'd4,
		loadHalfU = 3'd5
	} loadKind_t;

	typedef enum logic [1:0]
	{
		storeByte = 2'd0,
		storeHalf = 2'd1,
		storeWord = 2'd2
	} storeSize_t;

	//////////////////////////////////////////////////////////////////////
	// Bundles between stages
	//////////////////////////////////////////////////////////////////////

	// Operation offered by execute, 70 bits
	typedef struct packed
	{
		logic       isStore;
		loadKind_t  loadKind;
		storeSize_t storeSize;
		addr_t      addr;
		dataWord_t  storeData;
	} memOpReq_t;

	// Checked and lane-placed operation
	typedef struct packed
	{
		logic        isStore;
		loadKind_t   loadKind;
		logic        misaligned;
		addr_t       wordAddr;
		byteOffset_t byteOffset;
		byteSel_t    sel;
		dataWord_t   writeData;
	} stagedOp_t;

	// Wishbone, master side
	typedef struct packed
	{
		logic      cyc;
		logic      stb;
		logic      we;
		addr_t     adr;
		byteSel_t  sel;
		dataWord_t datW;
	} wbMaster_t;

	// Wishbone, slave side
	typedef struct packed
	{
		logic      ack;
		dataWord_t datR;
	} wbSlave_t;

	// Completion toward writeback
	typedef struct packed
	{
		logic      isLoad;
		logic      misaligned;
		dataWord_t data;
	} memResult_t;

endpackage

`default_nettype wire

/* logic/loadExtender.sv */
`timescale 1ns/1ps
`default_nettype none

module loadExtender
	import memStagePkg::*;
(
	input  wire loadKind_t loadKind,
	input  wire dataWord_t rawWord,
	output dataWord_t      extWord
);

	always_comb
	begin
		case (loadKind)
			// Full word either way
			loadWord, loadWordU:
			begin
				extWord = rawWord;
			end
			// Sign from bit 7
			loadByte:
			begin
				extWord = {{24{rawWord[7]}}, rawWord[7:0]};
			end
			loadByteU:
			begin
				extWord = {24'b0, rawWord[7:0]};
			end
			// Sign from bit 15
			loadHalf:
			begin
				extWord = {{16{rawWord[15]}}, rawWord[15:0]};
			end
			loadHalfU:
			begin
				extWord = {16'b0, rawWord[15:0]};
			end
			// Spare codes pass the word
			default:
			begin
				extWord = rawWord;
			end
		endcase
	end

endmodule

`default_nettype wire

/* memAccess/memRequestStage.sv */
`timescale 1ns/1ps
`default_nettype none

module memRequestStage
	import memStagePkg::*;
#(
	parameter int ramAddrBits = 8
)
(
	input  wire        clk,
	input  wire        rstN,
	input  wire        memOpReq_t opReq,
	input  wire        opValid,
	output logic       opReady,
	output stagedOp_t  staged,
	output logic       stagedValid,
	input  wire        stagedReady
);

	// Access width, taken from the load kind for loads
	storeSize_t accessSize;
	logic       misaligned;
	byteSel_t   sel;
	dataWord_t  laneData;
	stagedOp_t  nextOp;
	logic       fullQ;

	always_comb
	begin
		if (opReq.isStore)
		begin
			accessSize = opReq.storeSize;
		end
		else
		begin
			case (opReq.loadKind)
				loadByte, loadByteU: accessSize = storeByte;
				loadHalf, loadHalfU: accessSize = storeHalf;
				// Word kinds and spare codes
				default:             accessSize = storeWord;
			endcase
		end
	end

	// Alignment and lane selects
	always_comb
	begin
		case (accessSize)
			storeByte:
			begin
				misaligned = 1'b0;
				sel        = byteSel_t'(4'b0001 << opReq.addr[1:0]);
				// Byte copied to every lane
				laneData   = {4{opReq.storeData[7:0]}};
			end
			storeHalf:
			begin
				misaligned = opReq.addr[0];
				sel        = opReq.addr[1] ? 4'b1100 : 4'b0011;
				laneData   = {2{opReq.storeData[15:0]}};
			end
			default:
			begin
				misaligned = (opReq.addr[1:0] != 2'b00);
				sel        = 4'b1111;
				laneData   = opReq.storeData;
			end
		endcase
	end

	always_comb
	begin
		nextOp.isStore    = opReq.isStore;
		nextOp.loadKind   = opReq.loadKind;
		nextOp.misaligned = misaligned;
		// Word index, cut to the RAM range
		nextOp.wordAddr   = addr_t'(opReq.addr[ramAddrBits+1:2]);
		nextOp.byteOffset = opReq.addr[1:0];
		nextOp.sel        = sel;
		nextOp.writeData  = opReq.isStore ? laneData : '0;
	end

	// Empty, or draining this cycle
	assign opReady     = !fullQ || stagedReady;
	assign stagedValid = fullQ;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			fullQ <= 1'b0;
		end
		else if (opValid && opReady)
		begin
			fullQ <= 1'b1;
		end
		else if (stagedReady)
		begin
			fullQ <= 1'b0;
		end
	end

	// Payload holding register
	always_ff @(posedge clk)
	begin
		if (opValid && opReady)
		begin
			staged <= nextOp;
		end
	end

	// Offer held until the bus stage takes it
	stagedHeld: assert property (@(posedge clk) disable iff (!rstN)
		stagedValid && !stagedReady |=> stagedValid);

endmodule

`default_nettype wire

/* memAccess/memBusMaster.sv */
`timescale 1ns/1ps
`default_nettype none

module memBusMaster
	import memStagePkg::*;
(
	input  wire              clk,
	input  wire              rstN,
	input  wire stagedOp_t   staged,
	input  wire              stagedValid,
	output logic             stagedReady,
	output wbMaster_t        wbOut,
	input  wire wbSlave_t    wbIn,
	output logic             doneValid,
	output logic             doneIsLoad,
	output loadKind_t        doneKind,
	output byteOffset_t      doneOffset,
	output logic             doneMisaligned,
	output dataWord_t        doneData
);

	typedef enum logic [1:0]
	{
		idle,
		busCycle,
		finish
	} busState_t;

	busState_t state;
	// Operation under way
	stagedOp_t curOp;
	// Word returned with ack
	dataWord_t readWord;
	logic      accept;
	logic      busActive;

	assign stagedReady = (state == idle);
	assign accept      = stagedValid && stagedReady;

	//////////////////////////////////////////////////////////////////////
	// State machine
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= idle;
		end
		else
		begin
			case (state)
				idle:
				begin
					if (accept)
					begin
						state <= busCycle;
					end
				end
				busCycle:
				begin
					// Misaligned op spends this cycle off the bus
					if (curOp.misaligned || wbIn.ack)
					begin
						state <= finish;
					end
				end
				finish:
				begin
					state <= idle;
				end
				default:
				begin
					state <= idle;
				end
			endcase
		end
	end

	// Op capture
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			curOp <= staged;
		end
	end

	// Read data on ack
	always_ff @(posedge clk)
	begin
		if (state == busCycle && wbIn.ack)
		begin
			readWord <= wbIn.datR;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Wishbone drive
	//////////////////////////////////////////////////////////////////////

	// Cycle only for aligned ops and dropped on the ack edge
	assign busActive  = (state == busCycle) && !curOp.misaligned;
	assign wbOut.cyc  = busActive;
	assign wbOut.stb  = busActive;
	assign wbOut.we   = curOp.isStore;
	assign wbOut.adr  = curOp.wordAddr;
	assign wbOut.sel  = curOp.sel;
	assign wbOut.datW = curOp.writeData;

	// Completion lasts the one finish cycle
	assign doneValid      = (state == finish);
	assign doneIsLoad     = !curOp.isStore;
	assign doneKind       = curOp.loadKind;
	assign doneOffset     = curOp.byteOffset;
	assign doneMisaligned = curOp.misaligned;
	assign doneData       = readWord;

	// Ack only answers a live strobe inside the cycle
	ackInsideStb: assert property (@(posedge clk) disable iff (!rstN)
		wbIn.ack |-> wbOut.stb && wbOut.cyc);

	// Address held through the wait
	adrStable: assert property (@(posedge clk) disable iff (!rstN)
		wbOut.stb && !wbIn.ack |=> $stable(wbOut.adr));

endmodule

`default_nettype wire

/* dataRam/dataRam.sv */
`timescale 1ns/1ps
`default_nettype none

module dataRam
	import memStagePkg::*;
#(
	parameter int ramAddrBits = 8
)
(
	input  wire            clk,
	input  wire            rstN,
	input  wire wbMaster_t wbIn,
	output wbSlave_t       wbOut
);

	localparam int words = 2 ** ramAddrBits;

	dataWord_t                mem [words];
	logic [ramAddrBits-1:0]   wordIdx;
	logic                     ackQ;
	dataWord_t                readQ;
	// New strobe, not the one just acked
	logic                     hit;

	assign wordIdx = wbIn.adr[ramAddrBits-1:0];
	assign hit     = wbIn.cyc && wbIn.stb && !ackQ;

	// Power-up contents are zero
	initial
	begin
		for (int i = 0; i < words; i++)
		begin
			mem[i] = '0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////////////////////////

	// Write only the selected lanes
	always_ff @(posedge clk)
	begin
		if (hit && wbIn.we)
		begin
			for (int b = 0; b < 4; b++)
			begin
				if (wbIn.sel[b])
				begin
					mem[wordIdx][b*8 +: 8] <= wbIn.datW[b*8 +: 8];
				end
			end
		end
	end

	// Whole word read, lines up with ack
	always_ff @(posedge clk)
	begin
		if (hit)
		begin
			readQ <= mem[wordIdx];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Acknowledge
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			ackQ <= 1'b0;
		end
		else
		begin
			ackQ <= hit;
		end
	end

	assign wbOut.ack  = ackQ;
	assign wbOut.datR = readQ;

	ackAfterStb: assert property (@(posedge clk) disable iff (!rstN)
		wbOut.ack |-> $past(wbIn.cyc && wbIn.stb));

endmodule

`default_nettype wire

/* logic/loadResultStage.sv */
`timescale 1ns/1ps
`default_nettype none

module loadResultStage
	import memStagePkg::*;
(
	input  wire              clk,
	input  wire              rstN,
	input  wire              doneValid,
	input  wire              doneIsLoad,
	input  wire loadKind_t   doneKind,
	input  wire byteOffset_t doneOffset,
	input  wire              doneMisaligned,
	input  wire dataWord_t   doneData,
	output memResult_t       result,
	output logic             resultValid
);

	// Addressed lane moved to bit 0
	dataWord_t shifted;
	dataWord_t extended;
	memResult_t nextResult;

	assign shifted = doneData >> {doneOffset, 3'b000};

	loadExtender extend
	(
		.loadKind (doneKind),
		.rawWord  (shifted),
		.extWord  (extended)
	);

	always_comb
	begin
		nextResult.isLoad     = doneIsLoad;
		nextResult.misaligned = doneMisaligned;
		// Stores and misaligned ops report zero
		nextResult.data       = (doneIsLoad && !doneMisaligned) ? extended : '0;
	end

	//////////////////////////////////////////////////////////////////////
	// Completion register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			resultValid <= 1'b0;
		end
		else
		begin
			// One pulse per done
			resultValid <= doneValid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (doneValid)
		begin
			result <= nextResult;
		end
	end

endmodule

`default_nettype wire

/* logic/memStageTop.sv */
`timescale 1ns/1ps
`default_nettype none

module memStageTop
	import memStagePkg::*;
#(
	parameter int ramAddrBits = 8
)
(
	input  wire            clk,
	input  wire            rstN,
	input  wire memOpReq_t opReq,
	input  wire            opValid,
	output logic           opReady,
	output memResult_t     result,
	output logic           resultValid
);

	// Request to bus stage
	stagedOp_t   staged;
	logic        stagedValid;
	logic        stagedReady;
	// Wishbone
	wbMaster_t   wbM;
	wbSlave_t    wbS;
	// Bus stage completion
	logic        doneValid;
	logic        doneIsLoad;
	loadKind_t   doneKind;
	byteOffset_t doneOffset;
	logic        doneMisaligned;
	dataWord_t   doneData;

	memRequestStage #(.ramAddrBits(ramAddrBits)) request
	(
		.clk         (clk),
		.rstN        (rstN),
		.opReq       (opReq),
		.opValid     (opValid),
		.opReady     (opReady),
		.staged      (staged),
		.stagedValid (stagedValid),
		.stagedReady (stagedReady)
	);

	memBusMaster busMaster
	(
		.clk            (clk),
		.rstN           (rstN),
		.staged         (staged),
		.stagedValid    (stagedValid),
		.stagedReady    (stagedReady),
		.wbOut          (wbM),
		.wbIn           (wbS),
		.doneValid      (doneValid),
		.doneIsLoad     (doneIsLoad),
		.doneKind       (doneKind),
		.doneOffset     (doneOffset),
		.doneMisaligned (doneMisaligned),
		.doneData       (doneData)
	);

	dataRam #(.ramAddrBits(ramAddrBits)) ram
	(
		.clk   (clk),
		.rstN  (rstN),
		.wbIn  (wbM),
		.wbOut (wbS)
	);

	loadResultStage loadResult
	(
		.clk            (clk),
		.rstN           (rstN),
		.doneValid      (doneValid),
		.doneIsLoad     (doneIsLoad),
		.doneKind       (doneKind),
		.doneOffset     (doneOffset),
		.doneMisaligned (doneMisaligned),
		.doneData       (doneData),
		.result         (result),
		.resultValid    (resultValid)
	);

endmodule

`default_nettype wire

/* verification/memStageTb.sv */
`timescale 1ns/1ps
`default_nettype none

module memStageTb
	import memStagePkg::*;
();

	// One table row: operation plus what it should report
	typedef struct packed
	{
		logic       isStore;
		loadKind_t  kind;
		storeSize_t size;
		addr_t      addr;
		dataWord_t  data;
		// Store data drawn from $urandom
		logic       rnd;
		logic       misExp;
		// Pipeline drained first, latency checked
		logic       isolated;
	} rowSpec_t;

	// Outstanding completion
	typedef struct packed
	{
		memResult_t  exp;
		logic [31:0] row;
		logic [31:0] xferCycle;
		logic        isolated;
	} expEntry_t;

	logic       clk;
	logic       rstN;
	memOpReq_t  opReq;
	logic       opValid;
	logic       opReady;
	memResult_t result;
	logic       resultValid;

	rowSpec_t   rows[$];
	string      labels[$];
	expEntry_t  expQ[$];
	// Byte-wide model of the RAM contents
	logic [7:0] refMem [1024];
	int         numRows = 0;
	int         cycleCount = 0;
	int         errors = 0;
	int         checks = 0;
	int         completed = 0;
	expEntry_t  cur;
	int         rowErrs;
	int         latency;

	memStageTop #(.ramAddrBits(8)) UUT
	(
		.clk         (clk),
		.rstN        (rstN),
		.opReq       (opReq),
		.opValid     (opValid),
		.opReady     (opReady),
		.result      (result),
		.resultValid (resultValid)
	);

	always
	begin
		#10 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
	end

	//////////////////////////////////////////////////////////////////////
	// Table and reference model
	//////////////////////////////////////////////////////////////////////

	task automatic addLoad(input loadKind_t kind, input addr_t addr, input logic mis,
		input logic iso, input string label);
		rows.push_back({1'b0, kind, storeWord, addr, 32'h0, 1'b0, mis, iso});
		labels.push_back(label);
	endtask

	task automatic addStore(input storeSize_t size, input addr_t addr, input dataWord_t data,
		input logic rnd, input logic mis, input logic iso, input string label);
		rows.push_back({1'b1, loadWord, size, addr, data, rnd, mis, iso});
		labels.push_back(label);
	endtask

	task automatic buildTable();
		// Never written
		addLoad(loadWord, 32'h100, 1'b0, 1'b1, "load unwritten word");
		// Word store, both word kinds
		addStore(storeWord, 32'h040, 32'h0, 1'b1, 1'b0, 1'b1, "store word");
		addLoad(loadWord, 32'h040, 1'b0, 0, "load word");
		addLoad(loadWordU, 32'h040, 1'b0, 0, "load word unsigned");
		// Byte lanes over a random word
		addStore(storeWord, 32'h080, 32'h0, 1'b1, 1'b0, 1'b0, "store word under lanes");
		addStore(storeByte, 32'h081, 32'h1234_56A5, 1'b0, 1'b0, 1'b0, "store byte lane 1");
		addLoad(loadWord, 32'h080, 1'b0, 1'b0, "word after lane 1");
		addStore(storeByte, 32'h080, 32'hCAFE_BE3C, 1'b0, 1'b0, 1'b0, "store byte lane 0");
		addStore(storeByte, 32'h082, 32'h0BAD_00F0, 1'b0, 1'b0, 1'b0, "store byte lane 2");
		addStore(storeByte, 32'h083, 32'hFFFF_FF07, 1'b0, 1'b0, 1'b1, "store byte lane 3");
		addLoad(loadWord, 32'h080, 1'b0, 1'b0, "word after all lanes");
		for (int k = 0; k < 4; k++)
		begin
			addLoad(loadByte, 32'h080 + k, 1'b0, 1'b0, "signed byte");
			addLoad(loadByteU, 32'h080 + k, 1'b0, 1'b0, "unsigned byte");
		end
		// Halfwords, sign from bit 15
		addStore(storeWord, 32'h0C0, 32'h0, 1'b1, 1'b0, 1'b0, "store word under halves");
		addStore(storeHalf, 32'h0C0, 32'h5555_8001, 1'b0, 1'b0, 1'b0, "store low half");
		addLoad(loadWord, 32'h0C0, 1'b0, 1'b0, "word after low half");
		addStore(storeHalf, 32'h0C2, 32'hAAAA_7FFE, 1'b0, 1'b0, 1'b0, "store high half");
		addLoad(loadHalf, 32'h0C0, 1'b0, 1'b0, "signed half offset 0");
		addLoad(loadHalfU, 32'h0C0, 1'b0, 1'b0, "unsigned half offset 0");
		addLoad(loadHalf, 32'h0C2, 1'b0, 1'b0, "signed half offset 2");
		addLoad(loadHalfU, 32'h0C2, 1'b0, 1'b0, "unsigned half offset 2");
		// Misaligned, bus untouched
		addLoad(loadHalf, 32'h0C1, 1'b1, 1'b1, "misaligned half load");
		addStore(storeHalf, 32'h0C3, 32'hFFFF_FFFF, 1'b0, 1'b1, 1'b0, "misaligned half store");
		addLoad(loadWord, 32'h0C2, 1'b1, 1'b0, "misaligned word load");
		addStore(storeWord, 32'h041, 32'h0, 1'b1, 1'b1, 1'b0, "misaligned word store");
		addLoad(loadWord, 32'h0C0, 1'b0, 1'b0, "halves unchanged");
		addLoad(loadWord, 32'h040, 1'b0, 1'b1, "word unchanged");
	endtask

	task automatic applyStore(input storeSize_t size, input logic [9:0] a, input dataWord_t data);
		int n;
		n = (size == storeByte) ? 1 : ((size == storeHalf) ? 2 : 4);
		for (int k = 0; k < n; k++)
		begin
			refMem[a + 10'(k)] = data[k*8 +: 8];
		end
	endtask

	// Little-endian gather, then extension by kind
	function automatic dataWord_t modelLoad(input loadKind_t kind, input logic [9:0] a);
		dataWord_t w;
		w = '0;
		for (int k = 3; k >= 0; k--)
		begin
			w = {w[23:0], refMem[a + 10'(k)]};
		end
		case (kind)
			loadByte:  return {{24{w[7]}}, w[7:0]};
			loadByteU: return {24'h0, w[7:0]};
			loadHalf:  return {{16{w[15]}}, w[15:0]};
			loadHalfU: return {16'h0, w[15:0]};
			default:   return w;
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Driver
	//////////////////////////////////////////////////////////////////////

	task automatic driveRow(input int idx);
		rowSpec_t  spec;
		dataWord_t data;
		expEntry_t entry;
		spec = rows[idx];
		data = spec.rnd ? $urandom() : spec.data;
		opReq.isStore   = spec.isStore;
		opReq.loadKind  = spec.kind;
		opReq.storeSize = spec.size;
		opReq.addr      = spec.addr;
		opReq.storeData = data;
		opValid         = 1'b1;
		// opReady only moves on rising edges
		while (!opReady)
		begin
			@(negedge clk);
		end
		// Transfer happens on the coming edge
		entry.row            = 32'(idx);
		entry.xferCycle      = 32'(cycleCount + 1);
		entry.isolated       = spec.isolated;
		entry.exp.isLoad     = !spec.isStore;
		entry.exp.misaligned = spec.misExp;
		entry.exp.data       = '0;
		if (!spec.misExp && spec.isStore)
		begin
			applyStore(spec.size, spec.addr[9:0], data);
		end
		else if (!spec.misExp)
		begin
			entry.exp.data = modelLoad(spec.kind, spec.addr[9:0]);
		end
		expQ.push_back(entry);
		@(negedge clk);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Completion monitor
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk)
	begin
		if (rstN && resultValid)
		begin
			if (expQ.size() == 0)
			begin
				$display("Completion at %0t with no operation outstanding", $time);
				errors++;
			end
			else
			begin
				cur = expQ.pop_front();
				rowErrs = 0;
				latency = cycleCount - int'(cur.xferCycle);
				assert (result.isLoad == cur.exp.isLoad)
				else
				begin
					$display("FAIL %0t: row %0d isLoad %0b, expected %0b", $time, cur.row,
						result.isLoad, cur.exp.isLoad);
					rowErrs++;
				end
				assert (result.misaligned == cur.exp.misaligned)
				else
				begin
					$display("FAIL %0t: row %0d misaligned %0b, expected %0b", $time, cur.row,
						result.misaligned, cur.exp.misaligned);
					rowErrs++;
				end
				assert (result.data == cur.exp.data)
				else
				begin
					$display("FAIL %0t: row %0d data %h, expected %h", $time, cur.row,
						result.data, cur.exp.data);
					rowErrs++;
				end
				checks += 3;
				// Exact latency only with an empty pipeline
				if (cur.isolated)
				begin
					checks++;
					assert (latency == (cur.exp.misaligned ? 3 : 4))
					else
					begin
						$display("FAIL %0t: row %0d latency %0d cycles", $time, cur.row, latency);
						rowErrs++;
					end
				end
				errors += rowErrs;
				completed++;
				$display("Row %0d %s: %s", cur.row, labels[cur.row],
					(rowErrs == 0) ? "ok" : "mismatch");
			end
		end
	end

	// Bound scales with the table
	initial
	begin
		wait (numRows > 0);
		repeat (numRows * 10 + 100) @(posedge clk);
		$display("Timeout: operations did not complete within the allowed cycles");
		$display("Test failed");
		$finish;
	end

	initial
	begin
		clk     = 1'b0;
		rstN    = 1'b0;
		opValid = 1'b0;
		opReq   = '0;
		void'($urandom(32'h9a641e51));
		for (int i = 0; i < 1024; i++)
		begin
			refMem[i] = 8'h00;
		end
		buildTable();
		numRows = rows.size();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		@(negedge clk);
		assert (!resultValid)
		else
		begin
			$display("FAIL %0t: resultValid high after reset", $time);
			errors++;
		end
		assert (opReady)
		else
		begin
			$display("FAIL %0t: opReady low after reset", $time);
			errors++;
		end
		for (int i = 0; i < numRows; i++)
		begin
			if (rows[i].isolated)
			begin
				opValid = 1'b0;
				while (expQ.size() != 0)
				begin
					@(negedge clk);
				end
			end
			driveRow(i);
		end
		opValid = 1'b0;
		while (expQ.size() != 0)
		begin
			@(negedge clk);
		end
		// Catch stray pulses
		repeat (4) @(negedge clk);
		if (completed != numRows)
		begin
			$display("Only %0d of %0d operations completed", completed, numRows);
			errors++;
		end
		$display("Rows %0d, completed %0d, checks %0d, errors %0d", numRows, completed,
			checks, errors);
		if (errors == 0)
		begin
			$display("Test completed successfully");
		end
		else
		begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
common/memStagePkg.sv
logic/loadExtender.sv
memAccess/memRequestStage.sv
memAccess/memBusMaster.sv
dataRam/dataRam.sv
logic/loadResultStage.sv
logic/memStageTop.sv
verification/memStageTb.sv

/* run.sh */
#!/bin/sh
# Build the memory stage testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module memStageTb \
	-o memStageSim &&
./obj_dir/memStageSim | tee /dev/stderr | grep "Test completed successfully" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
